// File: eth_pcs_consts.svh
// Quad PCS constants
`ifndef ETH_PCS_CONSTS_SVH
`define ETH_PCS_CONSTS_SVH

// Channels in the quad
`define ETH_PCS_CH_CNT 4

// Cycles from reset release to PLL lock
`define ETH_PCS_PLL_LOCK_CYCLES 20

// Block lock search
`define ETH_PCS_LOCK_GOOD_CNT 64
`define ETH_PCS_UNLOCK_BAD_CNT 16
`define ETH_PCS_BITSLIP_HIGH_CYCLES 0
`define ETH_PCS_BITSLIP_LOW_CYCLES 7

// BER window, shortened for simulation
`define ETH_PCS_COUNT_125US 256
`define ETH_PCS_BER_BAD_CNT 16

`endif

// File: eth_pcs_pkg.sv
// Quad PCS shared types

`resetall
`default_nettype none

package eth_pcs_pkg;

    // Sync header, 00 and 11 are invalid
    typedef enum logic [1:0] {
        HDR_DATA = 2'b01,
        HDR_CTRL = 2'b10
    } sync_hdr_e;

    // Header in the low bits, first on the wire
    typedef struct packed {
        logic [63:0] data;
        sync_hdr_e   hdr;
    } pcs_block_t;

    typedef enum logic [1:0] {
        ST_RESET,
        ST_WAIT_PLL,
        ST_WAIT_LOCK,
        ST_LINK_UP
    } link_state_e;

    typedef struct packed {
        logic block_lock;
        logic high_ber;
        logic status;
    } ch_status_t;

endpackage

`resetall

// File: eth_pcs_scrambler.sv
// 64b/66b scrambler and descrambler

`resetall
`default_nettype none

module eth_pcs_scrambler import eth_pcs_pkg::*; #(
    parameter bit DESCRAMBLE = 1'b0
) (
    input  wire logic       xcvr_ctrl_clk,
    input  wire logic       arst_n,
    input  wire pcs_block_t in_block,
    output pcs_block_t      out_block
);

// x^58 + x^39 + 1, state bit 0 holds the newest bit
logic [57:0] scr_state;
logic [57:0] scr_next;
logic [63:0] data_out;

always_comb begin
    logic bit_out;

    scr_next = scr_state;
    data_out = '0;
    // Data bit 0 goes out first
    for (int i = 0; i < 64; i++) begin
        bit_out = in_block.data[i] ^ scr_next[38] ^ scr_next[57];
        data_out[i] = bit_out;
        // Descrambler shifts in the line bits, so it resyncs by itself
        scr_next = {scr_next[56:0], DESCRAMBLE ? in_block.data[i] : bit_out};
    end
end

always_ff @(posedge xcvr_ctrl_clk or negedge arst_n) begin
    if (!arst_n) begin
        scr_state <= '1;
    end else begin
        scr_state <= scr_next;
    end
end

// Header passes unchanged
always_ff @(posedge xcvr_ctrl_clk) begin
    out_block.hdr <= in_block.hdr;
    out_block.data <= data_out;
end

endmodule

`resetall

// File: eth_pcs_rx_aligner.sv
// Receive bitslip barrel aligner

`resetall
`default_nettype none

module eth_pcs_rx_aligner import eth_pcs_pkg::*; (
    input  wire logic        xcvr_ctrl_clk,
    input  wire logic        arst_n,
    input  wire logic [65:0] serdes_word,
    input  wire logic        bitslip,
    output pcs_block_t       out_block
);

localparam int W = $bits(pcs_block_t);

logic [W-1:0] prev_word;
logic [6:0] offset;
logic [2*W-1:0] word_pair;

// Older word in the low half, matching wire order
assign word_pair = {serdes_word, prev_word};

always_ff @(posedge xcvr_ctrl_clk or negedge arst_n) begin
    if (!arst_n) begin
        offset <= '0;
    end else if (bitslip) begin
        // One bit per slip, wrapping after the last position
        if (offset == 7'(W - 1)) begin
            offset <= '0;
        end else begin
            offset <= offset + 1'b1;
        end
    end
end

// History word plus output stage, two cycles at any offset
always_ff @(posedge xcvr_ctrl_clk) begin
    prev_word <= serdes_word;
    out_block <= word_pair[offset +: W];
end

a_offset_range: assert property (
    @(posedge xcvr_ctrl_clk) disable iff (!arst_n)
    offset < 7'(W)
);

endmodule

`resetall

// File: eth_pcs_block_lock.sv
// Sync header block lock

`resetall
`default_nettype none

`include "eth_pcs_consts.svh"

module eth_pcs_block_lock import eth_pcs_pkg::*; (
    input  wire logic      xcvr_ctrl_clk,
    input  wire logic      arst_n,
    input  wire logic      pcs_rst,
    input  wire sync_hdr_e hdr,
    output logic           block_lock,
    output logic           bitslip,
    output logic           hdr_bad
);

localparam int GOOD_W = $clog2(`ETH_PCS_LOCK_GOOD_CNT);
localparam int BAD_W = $clog2(`ETH_PCS_UNLOCK_BAD_CNT);
localparam int SPAN_W = 6;
localparam int SLIP_WAIT = `ETH_PCS_BITSLIP_HIGH_CYCLES + `ETH_PCS_BITSLIP_LOW_CYCLES;
localparam int WAIT_W = $clog2(SLIP_WAIT + 1);

logic [GOOD_W-1:0] good_cnt;
logic [BAD_W-1:0] bad_cnt;
logic [SPAN_W-1:0] span_cnt;
logic [WAIT_W-1:0] wait_cnt;
logic hdr_valid;
logic judge;

assign hdr_valid = (hdr == HDR_DATA) || (hdr == HDR_CTRL);
// Headers right after a slip are not judged
assign judge = (wait_cnt == '0);

always_ff @(posedge xcvr_ctrl_clk or negedge arst_n) begin
    if (!arst_n) begin
        block_lock <= 1'b0;
        bitslip <= 1'b0;
        hdr_bad <= 1'b0;
        good_cnt <= '0;
        bad_cnt <= '0;
        span_cnt <= '0;
        wait_cnt <= '0;
    end else if (pcs_rst) begin
        block_lock <= 1'b0;
        bitslip <= 1'b0;
        hdr_bad <= 1'b0;
        good_cnt <= '0;
        bad_cnt <= '0;
        span_cnt <= '0;
        wait_cnt <= '0;
    end else begin
        bitslip <= 1'b0;
        hdr_bad <= judge && !hdr_valid;
        if (!judge) begin
            wait_cnt <= wait_cnt - 1'b1;
        end else if (!block_lock) begin
            span_cnt <= '0;
            bad_cnt <= '0;
            if (hdr_valid) begin
                if (good_cnt == GOOD_W'(`ETH_PCS_LOCK_GOOD_CNT - 1)) begin
                    block_lock <= 1'b1;
                    good_cnt <= '0;
                end else begin
                    good_cnt <= good_cnt + 1'b1;
                end
            end else begin
                // Try the next bit position
                good_cnt <= '0;
                bitslip <= 1'b1;
                wait_cnt <= WAIT_W'(SLIP_WAIT);
            end
        end else begin
            span_cnt <= span_cnt + 1'b1;
            if (!hdr_valid && bad_cnt == BAD_W'(`ETH_PCS_UNLOCK_BAD_CNT - 1)) begin
                block_lock <= 1'b0;
                bad_cnt <= '0;
            end else if (span_cnt == '1) begin
                bad_cnt <= '0;
            end else if (!hdr_valid) begin
                bad_cnt <= bad_cnt + 1'b1;
            end
        end
    end
end

a_no_slip_in_lock: assert property (
    @(posedge xcvr_ctrl_clk) disable iff (!arst_n)
    bitslip |-> !block_lock ##1 !block_lock
);

endmodule

`resetall

// File: eth_pcs_ber_monitor.sv
// Windowed BER monitor

`resetall
`default_nettype none

`include "eth_pcs_consts.svh"

module eth_pcs_ber_monitor (
    input  wire logic xcvr_ctrl_clk,
    input  wire logic arst_n,
    input  wire logic pcs_rst,
    input  wire logic hdr_bad,
    output logic      high_ber
);

localparam int WIN_W = $clog2(`ETH_PCS_COUNT_125US);
localparam int BAD_W = $clog2(`ETH_PCS_BER_BAD_CNT + 1);

logic [WIN_W-1:0] win_cnt;
logic [BAD_W-1:0] bad_cnt;
logic [BAD_W-1:0] bad_cnt_next;
logic win_end;

assign win_end = (win_cnt == WIN_W'(`ETH_PCS_COUNT_125US - 1));

// Saturates at the threshold
always_comb begin
    bad_cnt_next = bad_cnt;
    if (hdr_bad && bad_cnt != BAD_W'(`ETH_PCS_BER_BAD_CNT)) begin
        bad_cnt_next = bad_cnt + 1'b1;
    end
end

always_ff @(posedge xcvr_ctrl_clk or negedge arst_n) begin
    if (!arst_n) begin
        win_cnt <= '0;
        bad_cnt <= '0;
        high_ber <= 1'b0;
    end else if (pcs_rst) begin
        win_cnt <= '0;
        bad_cnt <= '0;
        high_ber <= 1'b0;
    end else begin
        win_cnt <= win_end ? '0 : win_cnt + 1'b1;
        if (win_end) begin
            // Last cycle of the window counts too
            high_ber <= (bad_cnt_next == BAD_W'(`ETH_PCS_BER_BAD_CNT));
            bad_cnt <= '0;
        end else begin
            bad_cnt <= bad_cnt_next;
        end
    end
end

endmodule

`resetall

// File: eth_pcs_ch_ctrl.sv
// Channel reset and link control

`resetall
`default_nettype none

module eth_pcs_ch_ctrl import eth_pcs_pkg::*; (
    input  wire logic xcvr_ctrl_clk,
    input  wire logic arst_n,
    input  wire logic qpll_lock,
    input  wire logic block_lock,
    input  wire logic high_ber,
    output logic      pcs_rst,
    output logic      status
);

link_state_e state;
link_state_e state_next;

always_comb begin
    state_next = state;
    case (state)
        ST_RESET: begin
            state_next = ST_WAIT_PLL;
        end
        ST_WAIT_PLL: begin
            if (qpll_lock) begin
                state_next = ST_WAIT_LOCK;
            end
        end
        ST_WAIT_LOCK: begin
            if (!qpll_lock) begin
                state_next = ST_WAIT_PLL;
            end else if (block_lock && !high_ber) begin
                state_next = ST_LINK_UP;
            end
        end
        ST_LINK_UP: begin
            if (!qpll_lock) begin
                state_next = ST_WAIT_PLL;
            end else if (!block_lock || high_ber) begin
                state_next = ST_WAIT_LOCK;
            end
        end
        default: begin
            state_next = ST_RESET;
        end
    endcase
end

always_ff @(posedge xcvr_ctrl_clk or negedge arst_n) begin
    if (!arst_n) begin
        state <= ST_RESET;
    end else begin
        state <= state_next;
    end
end

// Receive path held until the PLL is up
assign pcs_rst = (state == ST_RESET) || (state == ST_WAIT_PLL);

// Drops in the cycle lock is lost or BER goes high
assign status = (state == ST_LINK_UP) && block_lock && !high_ber;

a_status_needs_pll: assert property (
    @(posedge xcvr_ctrl_clk) disable iff (!arst_n)
    status |-> qpll_lock
);

endmodule

`resetall

// File: eth_pcs_ch.sv
// 64b/66b PCS channel

`resetall
`default_nettype none

`include "eth_pcs_consts.svh"

module eth_pcs_ch import eth_pcs_pkg::*; #(
    parameter bit HAS_COMMON = 1'b0
) (
    input  wire logic        xcvr_ctrl_clk,
    input  wire logic        arst_n,

    // Common PLL
    input  wire logic        qpll_lock_in,
    output logic             qpll_lock_out,

    // Transmit
    input  wire pcs_block_t  tx_block,
    output logic [65:0]      tx_serdes,

    // Receive
    input  wire logic [65:0] rx_serdes,
    output pcs_block_t       rx_block,
    output ch_status_t       ch_status
);

pcs_block_t rx_aligned;
logic bitslip;
logic hdr_bad;
logic block_lock;
logic high_ber;
logic pcs_rst;
logic status;

if (HAS_COMMON) begin : g_common
    localparam int PLL_W = $clog2(`ETH_PCS_PLL_LOCK_CYCLES + 1);

    logic [PLL_W-1:0] pll_cnt;
    logic pll_lock;

    // PLL lock model, fixed delay after reset
    always_ff @(posedge xcvr_ctrl_clk or negedge arst_n) begin
        if (!arst_n) begin
            pll_cnt <= '0;
            pll_lock <= 1'b0;
        end else if (!pll_lock) begin
            pll_cnt <= pll_cnt + 1'b1;
            if (pll_cnt == PLL_W'(`ETH_PCS_PLL_LOCK_CYCLES - 1)) begin
                pll_lock <= 1'b1;
            end
        end
    end

    assign qpll_lock_out = pll_lock;
end else begin : g_no_common
    assign qpll_lock_out = 1'b0;
end

eth_pcs_scrambler #(
    .DESCRAMBLE(1'b0)
) tx_scrambler_i (
    .xcvr_ctrl_clk(xcvr_ctrl_clk),
    .arst_n(arst_n),
    .in_block(tx_block),
    .out_block(tx_serdes)
);

eth_pcs_rx_aligner rx_aligner_i (
    .xcvr_ctrl_clk(xcvr_ctrl_clk),
    .arst_n(arst_n),
    .serdes_word(rx_serdes),
    .bitslip(bitslip),
    .out_block(rx_aligned)
);

eth_pcs_block_lock block_lock_i (
    .xcvr_ctrl_clk(xcvr_ctrl_clk),
    .arst_n(arst_n),
    .pcs_rst(pcs_rst),
    .hdr(rx_aligned.hdr),
    .block_lock(block_lock),
    .bitslip(bitslip),
    .hdr_bad(hdr_bad)
);

eth_pcs_ber_monitor ber_monitor_i (
    .xcvr_ctrl_clk(xcvr_ctrl_clk),
    .arst_n(arst_n),
    .pcs_rst(pcs_rst),
    .hdr_bad(hdr_bad),
    .high_ber(high_ber)
);

eth_pcs_scrambler #(
    .DESCRAMBLE(1'b1)
) rx_descrambler_i (
    .xcvr_ctrl_clk(xcvr_ctrl_clk),
    .arst_n(arst_n),
    .in_block(rx_aligned),
    .out_block(rx_block)
);

eth_pcs_ch_ctrl ch_ctrl_i (
    .xcvr_ctrl_clk(xcvr_ctrl_clk),
    .arst_n(arst_n),
    .qpll_lock(qpll_lock_in),
    .block_lock(block_lock),
    .high_ber(high_ber),
    .pcs_rst(pcs_rst),
    .status(status)
);

assign ch_status.block_lock = block_lock;
assign ch_status.high_ber = high_ber;
assign ch_status.status = status;

endmodule

`resetall

// File: eth_pcs_quad.sv
// Quad 64b/66b PCS

`resetall
`default_nettype none

`include "eth_pcs_consts.svh"

module eth_pcs_quad import eth_pcs_pkg::*; (
    input  wire logic                               xcvr_ctrl_clk,
    input  wire logic                               arst_n,

    // Transmit blocks, one per clock
    input  wire pcs_block_t [`ETH_PCS_CH_CNT-1:0]   tx_block,

    // Serdes words
    output logic [`ETH_PCS_CH_CNT-1:0][65:0]        tx_serdes,
    input  wire logic [`ETH_PCS_CH_CNT-1:0][65:0]   rx_serdes,

    // Receive blocks and status
    output pcs_block_t [`ETH_PCS_CH_CNT-1:0]        rx_block,
    output ch_status_t [`ETH_PCS_CH_CNT-1:0]        rx_ch_status,

    // Common
    output logic                                    qpll_lock
);

for (genvar n = 0; n < `ETH_PCS_CH_CNT; n++) begin : g_ch
    localparam bit HAS_COMMON = (n == 0);

    logic ch_qpll_lock;

    // Channel 0 hosts the PLL and feeds all lanes
    if (HAS_COMMON) begin : g_common
        assign qpll_lock = ch_qpll_lock;
    end

    eth_pcs_ch #(
        .HAS_COMMON(HAS_COMMON)
    ) ch_i (
        .xcvr_ctrl_clk(xcvr_ctrl_clk),
        .arst_n(arst_n),
        .qpll_lock_in(qpll_lock),
        .qpll_lock_out(ch_qpll_lock),
        .tx_block(tx_block[n]),
        .tx_serdes(tx_serdes[n]),
        .rx_serdes(rx_serdes[n]),
        .rx_block(rx_block[n]),
        .ch_status(rx_ch_status[n])
    );
end

endmodule

`resetall

// File: tb_eth_pcs_quad.sv
// Quad PCS testbench

`include "eth_pcs_consts.svh"

module tb_eth_pcs_quad import eth_pcs_pkg::*; ();

localparam int CH = `ETH_PCS_CH_CNT;
localparam int WIN = `ETH_PCS_COUNT_125US;
localparam int LOCK_CYCLES = 65 * 8 + 64;
localparam int WATCHDOG_CYCLES = 2 + `ETH_PCS_PLL_LOCK_CYCLES + 2 * LOCK_CYCLES + 3 * WIN + 1500;

logic xcvr_ctrl_clk;
logic arst_n;
pcs_block_t [CH-1:0] tx_block;
logic [CH-1:0][65:0] tx_serdes;
logic [CH-1:0][65:0] rx_serdes;
pcs_block_t [CH-1:0] rx_block;
ch_status_t [CH-1:0] rx_ch_status;
logic qpll_lock;

logic [CH-1:0][65:0] tx_prev;
pcs_block_t [CH-1:0][3:0] tx_hist;
logic [63:0] rnd;
int bad_left;
int cyc_since_rst;
logic hold_others;
int data_errs;
int state_errs;
int flow_errs;
int ctrl_seen;
int data_seen;

eth_pcs_quad eth_pcs_quad_i (
    .xcvr_ctrl_clk(xcvr_ctrl_clk),
    .arst_n(arst_n),
    .tx_block(tx_block),
    .tx_serdes(tx_serdes),
    .rx_serdes(rx_serdes),
    .rx_block(rx_block),
    .rx_ch_status(rx_ch_status),
    .qpll_lock(qpll_lock)
);

initial begin
    xcvr_ctrl_clk = 1'b0;
    forever #2 xcvr_ctrl_clk = ~xcvr_ctrl_clk;
end

function automatic logic [63:0] xorshift64(input logic [63:0] s);
    logic [63:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 7;
    x ^= x << 17;
    return x;
endfunction

// Random blocks on the falling edge once reset is released
always @(negedge xcvr_ctrl_clk) begin
    if (arst_n) begin
        for (int n = 0; n < CH; n++) begin
            rnd = xorshift64(rnd);
            tx_block[n].data = rnd;
            rnd = xorshift64(rnd);
            // Lane 2 carries invalid headers on request
            if (n == 2 && bad_left > 0) begin
                tx_block[n].hdr = sync_hdr_e'(2'b00);
            end else begin
                tx_block[n].hdr = rnd[0] ? HDR_CTRL : HDR_DATA;
            end
        end
        if (bad_left > 0) begin
            bad_left--;
        end
    end
end

// Loopback as a continuous bit stream
always @(posedge xcvr_ctrl_clk) begin
    tx_prev <= tx_serdes;
end

for (genvar n = 0; n < CH; n++) begin : g_lane
    // Bit delay of this lane
    localparam int OFS = (n == 0) ? 0 : (n == 1) ? 5 : (n == 2) ? 33 : 65;

    logic [131:0] bit_pair;

    assign bit_pair = {tx_serdes[n], tx_prev[n]};
    assign rx_serdes[n] = bit_pair[66 - OFS +: 66];

    // rx_block follows tx_block by 4 cycles once the link is up
    a_rx_data: assert property (
        @(posedge xcvr_ctrl_clk) disable iff (!arst_n)
        rx_ch_status[n].status |-> rx_block[n] == tx_hist[n][3]
    ) else begin
        data_errs++;
        $display("** Error: rx_block[%0d] = %h, expected %h", n, rx_block[n], tx_hist[n][3]);
    end

    a_idle_before_pll: assert property (
        @(posedge xcvr_ctrl_clk) disable iff (!arst_n)
        !qpll_lock |-> rx_ch_status[n] == 3'b000
    ) else begin
        state_errs++;
        $display("** Error: rx_ch_status[%0d] = %h, expected %h", n, rx_ch_status[n], 3'h0);
    end

    // Link up means block lock held and BER low
    a_status_locked: assert property (
        @(posedge xcvr_ctrl_clk) disable iff (!arst_n)
        rx_ch_status[n].status |-> rx_ch_status[n] == 3'b101
    ) else begin
        state_errs++;
        $display("** Error: rx_ch_status[%0d] = %h, expected %h", n, rx_ch_status[n], 3'h5);
    end

    if (n != 2) begin : g_bystander
        a_keep_status: assert property (
            @(posedge xcvr_ctrl_clk) disable iff (!arst_n)
            hold_others |-> rx_ch_status[n].status
        ) else begin
            state_errs++;
            $display("** Error: rx_ch_status[%0d].status = %h, expected %h",
                     n, rx_ch_status[n].status, 1'b1);
        end
    end
end

// Four blocks of history per lane
always @(posedge xcvr_ctrl_clk) begin
    for (int n = 0; n < CH; n++) begin
        tx_hist[n] <= {tx_hist[n][2:0], tx_block[n]};
        if (rx_ch_status[n].status) begin
            if (tx_hist[n][3].hdr == HDR_CTRL) begin
                ctrl_seen++;
            end else if (tx_hist[n][3].hdr == HDR_DATA) begin
                data_seen++;
            end
        end
    end
    if (arst_n) begin
        cyc_since_rst <= cyc_since_rst + 1;
    end
end

a_pll_timing: assert property (
    @(posedge xcvr_ctrl_clk) disable iff (!arst_n)
    qpll_lock == (cyc_since_rst >= `ETH_PCS_PLL_LOCK_CYCLES)
) else begin
    state_errs++;
    $display("** Error: qpll_lock = %h, expected %h after %0d cycles",
             qpll_lock, cyc_since_rst >= `ETH_PCS_PLL_LOCK_CYCLES, cyc_since_rst);
end

task automatic wait_all_status(input int limit);
    int cnt;
    cnt = 0;
    while (!(rx_ch_status[0].status && rx_ch_status[1].status &&
             rx_ch_status[2].status && rx_ch_status[3].status) && cnt < limit) begin
        @(posedge xcvr_ctrl_clk);
        cnt++;
    end
    assert (cnt < limit) else begin
        flow_errs++;
        $display("Not every lane reached link status within %0d cycles", limit);
    end
endtask

task automatic wait_lane2(input logic want_up, input int limit);
    int cnt;
    cnt = 0;
    while ((want_up ? !rx_ch_status[2].status || rx_ch_status[2].high_ber
                    : !rx_ch_status[2].high_ber || rx_ch_status[2].status)
           && cnt < limit) begin
        @(posedge xcvr_ctrl_clk);
        cnt++;
    end
    assert (cnt < limit) else begin
        flow_errs++;
        $display("Lane 2 did not %s within %0d cycles",
                 want_up ? "relock" : "flag high BER", limit);
    end
endtask

task automatic report_counts();
    $display("errors: data=%0d state=%0d flow=%0d", data_errs, state_errs, flow_errs);
endtask

initial begin
    watchdog: begin
        repeat (WATCHDOG_CYCLES) @(posedge xcvr_ctrl_clk);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        report_counts();
        $display("=== FAIL ===");
        $finish;
    end
end

initial begin
    arst_n = 1'b0;
    tx_block = '0;
    rnd = 64'd8;
    bad_left = 0;
    cyc_since_rst = 0;
    hold_others = 1'b0;
    data_errs = 0;
    state_errs = 0;
    flow_errs = 0;
    ctrl_seen = 0;
    data_seen = 0;
    repeat (2) @(posedge xcvr_ctrl_clk);
    @(negedge xcvr_ctrl_clk);
    arst_n = 1'b1;

    // Lock search plus the BER windows it spans
    wait_all_status(`ETH_PCS_PLL_LOCK_CYCLES + LOCK_CYCLES + 3 * WIN);
    repeat (300) @(posedge xcvr_ctrl_clk);

    // Burst of invalid headers on lane 2
    hold_others = 1'b1;
    // Start early in a BER window so the whole burst falls inside it
    while ((cyc_since_rst - `ETH_PCS_PLL_LOCK_CYCLES) % WIN != 64) begin
        @(posedge xcvr_ctrl_clk);
    end
    bad_left = 20;
    wait_lane2(1'b0, 2 * WIN + 50);
    wait_lane2(1'b1, LOCK_CYCLES + 3 * WIN);
    repeat (100) @(posedge xcvr_ctrl_clk);
    hold_others = 1'b0;

    assert (ctrl_seen > 0 && data_seen > 0) else begin
        flow_errs++;
        $display("Not both header types crossed the link");
    end

    report_counts();
    if (data_errs + state_errs + flow_errs == 0) begin
        $display("=== PASS ===");
    end else begin
        $display("=== FAIL ===");
    end
    $finish;
end

endmodule

// File: flist.f
+incdir+.
eth_pcs_pkg.sv
eth_pcs_scrambler.sv
eth_pcs_rx_aligner.sv
eth_pcs_block_lock.sv
eth_pcs_ber_monitor.sv
eth_pcs_ch_ctrl.sv
eth_pcs_ch.sv
eth_pcs_quad.sv
tb_eth_pcs_quad.sv

// File: run.sh
#!/bin/sh
# Build and run the quad PCS testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_eth_pcs_quad -f flist.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0
